//--- source/line_pkg.sv
package line_pkg;

    typedef logic [63:0]  addr_t;
    typedef logic [63:0]  beat_t;
    typedef logic [7:0]   strb_t;
    typedef logic [511:0] line_t;
    typedef logic [1:0]   resp_t;
    typedef logic [3:0]   axi_id_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    localparam int LINE_BYTES = 64;
    localparam int BEATS      = 8;

    // fixed burst shape, one line per burst
    localparam logic [7:0] BURST_LEN  = 8'd7;    // beats minus one
    localparam logic [2:0] BURST_SIZE = 3'd3;    // 8 bytes per beat
    localparam logic [1:0] BURST_INCR = 2'd1;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_BUSY,
        PORT_DONE
    } port_state_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RADDR,
        M_RDATA,
        M_WRITE,    // aw and w run together
        M_WRESP
    } master_state_t;

endpackage

//--- source/line_req_if.sv
`timescale 1ns/100ps

interface line_req_if;

    // request side, held until ready
    logic                valid;
    logic                write;
    line_pkg::addr_t     addr;
    line_pkg::line_t     wdata;

    // answer side, valid only while ready is high
    logic                ready;
    line_pkg::line_t     rdata;
    line_pkg::resp_t     resp;

    modport port_mp (
        output valid,
        output write,
        output addr,
        output wdata,
        input  ready,
        input  rdata,
        input  resp
    );

    modport master_mp (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output ready,
        output rdata,
        output resp
    );

endinterface

//--- source/line_port.sv
`timescale 1ns/100ps

module line_port (
    input  logic                clock,
    input  logic                reset,

    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  logic                req_write_i,
    input  line_pkg::addr_t     req_addr_i,
    input  line_pkg::line_t     req_wdata_i,

    output logic                done_o,
    output line_pkg::line_t     done_rdata_o,
    output line_pkg::resp_t     done_resp_o,

    line_req_if.port_mp         lreq
);

    line_pkg::port_state_t state;

    logic                req_write_q;
    line_pkg::addr_t     req_addr_q;
    line_pkg::line_t     req_wdata_q;
    line_pkg::line_t     rdata_q;
    line_pkg::resp_t     resp_q;

    logic accept;
    logic lreq_fire;

    assign accept    = req_valid_i && req_ready_o;
    assign lreq_fire = lreq.valid && lreq.ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= line_pkg::PORT_IDLE;
        end else begin
            case (state)
                line_pkg::PORT_IDLE: begin
                    if (accept) begin
                        state <= line_pkg::PORT_BUSY;
                    end
                end
                line_pkg::PORT_BUSY: begin
                    if (lreq_fire) begin
                        state <= line_pkg::PORT_DONE;
                    end
                end
                line_pkg::PORT_DONE: begin
                    state <= line_pkg::PORT_IDLE;  // done pulse is a single cycle
                end
                default: begin
                    state <= line_pkg::PORT_IDLE;
                end
            endcase
        end
    end

    // request and answer payload
    always_ff @(posedge clock) begin
        if (accept) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i & ~line_pkg::addr_t'(line_pkg::LINE_BYTES - 1);
            req_wdata_q <= req_wdata_i;
        end
        if (lreq_fire) begin
            rdata_q <= lreq.rdata;
            resp_q  <= lreq.resp;
        end
    end

    assign req_ready_o = (state == line_pkg::PORT_IDLE);
    assign done_o      = (state == line_pkg::PORT_DONE);

    assign done_rdata_o = rdata_q;
    assign done_resp_o  = resp_q;

    assign lreq.valid = (state == line_pkg::PORT_BUSY);
    assign lreq.write = req_write_q;
    assign lreq.addr  = req_addr_q;    // already line aligned
    assign lreq.wdata = req_wdata_q;

endmodule

//--- source/axi_burst_master.sv
`timescale 1ns/100ps

module axi_burst_master (
    input  logic                   clock,
    input  logic                   reset,

    line_req_if.master_mp          lreq,

    // read address / read data
    output logic                   axi_ar_valid_o,
    input  logic                   axi_ar_ready_i,
    output line_pkg::addr_t        axi_ar_addr_o,
    output line_pkg::axi_id_t      axi_ar_id_o,
    output logic [7:0]             axi_ar_len_o,
    output logic [2:0]             axi_ar_size_o,
    output logic [1:0]             axi_ar_burst_o,
    input  logic                   axi_r_valid_i,
    output logic                   axi_r_ready_o,
    input  line_pkg::beat_t        axi_r_data_i,
    input  line_pkg::resp_t        axi_r_resp_i,
    input  logic                   axi_r_last_i,
    input  line_pkg::axi_id_t      axi_r_id_i,

    // write address / write data / write response
    output logic                   axi_aw_valid_o,
    input  logic                   axi_aw_ready_i,
    output line_pkg::addr_t        axi_aw_addr_o,
    output line_pkg::axi_id_t      axi_aw_id_o,
    output logic [7:0]             axi_aw_len_o,
    output logic [2:0]             axi_aw_size_o,
    output logic [1:0]             axi_aw_burst_o,
    output logic                   axi_w_valid_o,
    input  logic                   axi_w_ready_i,
    output line_pkg::beat_t        axi_w_data_o,
    output line_pkg::strb_t        axi_w_strb_o,
    output logic                   axi_w_last_o,
    input  logic                   axi_b_valid_i,
    output logic                   axi_b_ready_o,
    input  line_pkg::resp_t        axi_b_resp_i,
    input  line_pkg::axi_id_t      axi_b_id_i
);

    line_pkg::master_state_t state;

    logic [$clog2(line_pkg::BEATS)-1:0] beat_cnt;

    logic                ready_q;
    logic                aw_done;
    logic                w_done;
    line_pkg::line_t     rdata_q;
    line_pkg::resp_t     resp_q;

    logic                ar_fire;
    logic                r_fire;
    logic                aw_fire;
    logic                w_fire;
    logic                b_fire;
    logic                new_req;
    line_pkg::resp_t     r_beat_resp;
    line_pkg::resp_t     b_chk_resp;

    assign ar_fire = axi_ar_valid_o && axi_ar_ready_i;
    assign r_fire  = axi_r_valid_i && axi_r_ready_o;
    assign aw_fire = axi_aw_valid_o && axi_aw_ready_i;
    assign w_fire  = axi_w_valid_o && axi_w_ready_i;
    assign b_fire  = axi_b_valid_i && axi_b_ready_o;

    // valid is still up in the cycle ready pulses, skip it there
    assign new_req = lreq.valid && !ready_q;

    // a foreign id counts as a slave error
    assign r_beat_resp = (axi_r_id_i == '0) ? axi_r_resp_i : line_pkg::RESP_SLVERR;
    assign b_chk_resp  = (axi_b_id_i == '0) ? axi_b_resp_i : line_pkg::RESP_SLVERR;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= line_pkg::M_IDLE;
            ready_q  <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                line_pkg::M_IDLE: begin
                    if (new_req) begin
                        beat_cnt <= '0;
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                        state    <= lreq.write ? line_pkg::M_WRITE : line_pkg::M_RADDR;
                    end
                end
                line_pkg::M_RADDR: begin
                    if (ar_fire) begin
                        state <= line_pkg::M_RDATA;
                    end
                end
                line_pkg::M_RDATA: begin
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (axi_r_last_i) begin
                            ready_q <= 1'b1;
                            state   <= line_pkg::M_IDLE;
                        end
                    end
                end
                line_pkg::M_WRITE: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (axi_w_last_o) begin
                            w_done <= 1'b1;
                        end
                    end
                    // both phases complete, possibly in this very cycle
                    if ((aw_done || aw_fire) && (w_done || (w_fire && axi_w_last_o))) begin
                        state <= line_pkg::M_WRESP;
                    end
                end
                line_pkg::M_WRESP: begin
                    if (b_fire) begin
                        ready_q <= 1'b1;
                        state   <= line_pkg::M_IDLE;
                    end
                end
                default: begin
                    state <= line_pkg::M_IDLE;
                end
            endcase
        end
    end

    // read line assembly and merged response
    always_ff @(posedge clock) begin
        if (state == line_pkg::M_IDLE) begin
            resp_q <= line_pkg::RESP_OKAY;
        end
        if (r_fire) begin
            rdata_q[beat_cnt * $bits(line_pkg::beat_t) +: $bits(line_pkg::beat_t)] <= axi_r_data_i;
            if (resp_q == line_pkg::RESP_OKAY) begin
                resp_q <= r_beat_resp;   // first error sticks
            end
        end
        if (b_fire) begin
            resp_q <= b_chk_resp;
        end
    end

    assign lreq.ready = ready_q;
    assign lreq.rdata = rdata_q;
    assign lreq.resp  = resp_q;

    assign axi_ar_valid_o = (state == line_pkg::M_RADDR);
    assign axi_ar_addr_o  = lreq.addr;
    assign axi_ar_id_o    = '0;
    assign axi_ar_len_o   = line_pkg::BURST_LEN;
    assign axi_ar_size_o  = line_pkg::BURST_SIZE;
    assign axi_ar_burst_o = line_pkg::BURST_INCR;
    assign axi_r_ready_o  = (state == line_pkg::M_RDATA);

    assign axi_aw_valid_o = (state == line_pkg::M_WRITE) && !aw_done;
    assign axi_aw_addr_o  = lreq.addr;
    assign axi_aw_id_o    = '0;
    assign axi_aw_len_o   = line_pkg::BURST_LEN;
    assign axi_aw_size_o  = line_pkg::BURST_SIZE;
    assign axi_aw_burst_o = line_pkg::BURST_INCR;

    assign axi_w_valid_o = (state == line_pkg::M_WRITE) && !w_done;
    assign axi_w_data_o  = lreq.wdata[beat_cnt * $bits(line_pkg::beat_t) +:
                                      $bits(line_pkg::beat_t)];
    assign axi_w_strb_o  = '1;   // whole line every time
    assign axi_w_last_o  = (beat_cnt == line_pkg::BURST_LEN[$bits(beat_cnt)-1:0]);
    assign axi_b_ready_o = (state == line_pkg::M_WRESP);

endmodule

//--- source/line_mover_top.sv
`timescale 1ns/100ps

module line_mover_top (
    input  logic                   clock,
    input  logic                   reset,

    // cache side
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic                   req_write_i,
    input  line_pkg::addr_t        req_addr_i,
    input  line_pkg::line_t        req_wdata_i,
    output logic                   done_o,
    output line_pkg::line_t        done_rdata_o,
    output line_pkg::resp_t        done_resp_o,

    // AXI4 memory side
    output logic                   axi_ar_valid_o,
    input  logic                   axi_ar_ready_i,
    output line_pkg::addr_t        axi_ar_addr_o,
    output line_pkg::axi_id_t      axi_ar_id_o,
    output logic [7:0]             axi_ar_len_o,
    output logic [2:0]             axi_ar_size_o,
    output logic [1:0]             axi_ar_burst_o,
    input  logic                   axi_r_valid_i,
    output logic                   axi_r_ready_o,
    input  line_pkg::beat_t        axi_r_data_i,
    input  line_pkg::resp_t        axi_r_resp_i,
    input  logic                   axi_r_last_i,
    input  line_pkg::axi_id_t      axi_r_id_i,

    output logic                   axi_aw_valid_o,
    input  logic                   axi_aw_ready_i,
    output line_pkg::addr_t        axi_aw_addr_o,
    output line_pkg::axi_id_t      axi_aw_id_o,
    output logic [7:0]             axi_aw_len_o,
    output logic [2:0]             axi_aw_size_o,
    output logic [1:0]             axi_aw_burst_o,
    output logic                   axi_w_valid_o,
    input  logic                   axi_w_ready_i,
    output line_pkg::beat_t        axi_w_data_o,
    output line_pkg::strb_t        axi_w_strb_o,
    output logic                   axi_w_last_o,
    input  logic                   axi_b_valid_i,
    output logic                   axi_b_ready_o,
    input  line_pkg::resp_t        axi_b_resp_i,
    input  line_pkg::axi_id_t      axi_b_id_i
);

    line_req_if lreq_if ();

    line_port u_line_port (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .done_o       (done_o),
        .done_rdata_o (done_rdata_o),
        .done_resp_o  (done_resp_o),
        .lreq         (lreq_if.port_mp)
    );

    axi_burst_master u_axi_burst_master (
        .clock          (clock),
        .reset          (reset),
        .lreq           (lreq_if.master_mp),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_id_o    (axi_ar_id_o),
        .axi_ar_len_o   (axi_ar_len_o),
        .axi_ar_size_o  (axi_ar_size_o),
        .axi_ar_burst_o (axi_ar_burst_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_resp_i   (axi_r_resp_i),
        .axi_r_last_i   (axi_r_last_i),
        .axi_r_id_i     (axi_r_id_i),
        .axi_aw_valid_o (axi_aw_valid_o),
        .axi_aw_ready_i (axi_aw_ready_i),
        .axi_aw_addr_o  (axi_aw_addr_o),
        .axi_aw_id_o    (axi_aw_id_o),
        .axi_aw_len_o   (axi_aw_len_o),
        .axi_aw_size_o  (axi_aw_size_o),
        .axi_aw_burst_o (axi_aw_burst_o),
        .axi_w_valid_o  (axi_w_valid_o),
        .axi_w_ready_i  (axi_w_ready_i),
        .axi_w_data_o   (axi_w_data_o),
        .axi_w_strb_o   (axi_w_strb_o),
        .axi_w_last_o   (axi_w_last_o),
        .axi_b_valid_i  (axi_b_valid_i),
        .axi_b_ready_o  (axi_b_ready_o),
        .axi_b_resp_i   (axi_b_resp_i),
        .axi_b_id_i     (axi_b_id_i)
    );

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/100ps

// AXI4 slave memory, one read burst and one write burst at a time
module axi_mem_model #(
    parameter line_pkg::addr_t ERR_BASE = 64'h0,
    parameter line_pkg::addr_t ERR_SIZE = 64'h0
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               ar_valid_i,
    output logic               ar_ready_o,
    input  line_pkg::addr_t    ar_addr_i,
    output logic               r_valid_o,
    input  logic               r_ready_i,
    output line_pkg::beat_t    r_data_o,
    output line_pkg::resp_t    r_resp_o,
    output logic               r_last_o,
    input  logic               aw_valid_i,
    output logic               aw_ready_o,
    input  line_pkg::addr_t    aw_addr_i,
    input  logic               w_valid_i,
    output logic               w_ready_o,
    input  line_pkg::beat_t    w_data_i,
    input  logic               w_last_i,
    output logic               b_valid_o,
    input  logic               b_ready_i,
    output line_pkg::resp_t    b_resp_o
);

    line_pkg::beat_t mem [line_pkg::addr_t];    // sparse, unwritten beats read as zero
    line_pkg::beat_t wbuf [8];

    logic            rst, rd_active, aw_got, w_got, b_pend;
    logic            ar_hs, r_hs, aw_hs, w_hs, b_hs, w_lst;
    logic [2:0]      rd_cnt, w_cnt;
    logic [3:0]      k;
    line_pkg::addr_t rd_addr, wr_addr, ar_a, aw_a;
    line_pkg::beat_t w_d;

    function automatic logic in_window(input line_pkg::addr_t a);
        return (a >= ERR_BASE) && (a < ERR_BASE + ERR_SIZE);
    endfunction

    initial begin
        {ar_ready_o, r_valid_o, r_last_o, aw_ready_o, w_ready_o, b_valid_o} = '0;
        r_data_o = '0;
        r_resp_o = line_pkg::RESP_OKAY;
        b_resp_o = line_pkg::RESP_OKAY;
        {rd_active, aw_got, w_got, b_pend} = '0;
        rd_cnt  = '0;
        w_cnt   = '0;
        rd_addr = '0;
        wr_addr = '0;
        forever begin
            @(posedge clock);
            // handshakes and inputs as seen at the edge
            rst   = reset;
            ar_hs = ar_valid_i && ar_ready_o;
            r_hs  = r_valid_o && r_ready_i;
            aw_hs = aw_valid_i && aw_ready_o;
            w_hs  = w_valid_i && w_ready_o;
            b_hs  = b_valid_o && b_ready_i;
            ar_a  = ar_addr_i;
            aw_a  = aw_addr_i;
            w_d   = w_data_i;
            w_lst = w_last_i;
            #1;
            if (rst) begin
                {rd_active, aw_got, w_got, b_pend, r_valid_o, b_valid_o} = '0;
                rd_cnt = '0;
                w_cnt  = '0;
            end else begin
                if (ar_hs) begin
                    rd_active = 1'b1;
                    rd_addr   = ar_a;
                    rd_cnt    = '0;
                end
                if (r_hs) begin
                    r_valid_o = 1'b0;
                    rd_active = !r_last_o;
                    rd_cnt    = rd_cnt + 3'd1;
                end
                if (rd_active && !r_valid_o) begin
                    r_valid_o = ($urandom_range(0, 3) != 0);
                end
                if (aw_hs) begin
                    aw_got  = 1'b1;
                    wr_addr = aw_a;
                end
                if (w_hs) begin
                    wbuf[w_cnt] = w_d;
                    w_cnt       = w_cnt + 3'd1;    // wraps to zero after the eighth beat
                    w_got       = w_lst;
                end
                if (b_hs) begin
                    {b_valid_o, b_pend, aw_got, w_got} = '0;
                end
                if (aw_got && w_got && !b_pend) begin
                    if (!in_window(wr_addr)) begin
                        for (k = 0; k < 8; k++) begin
                            mem[wr_addr + {57'd0, k, 3'b000}] = wbuf[k[2:0]];
                        end
                    end
                    b_pend = 1'b1;
                end
                if (b_pend && !b_valid_o) begin
                    b_valid_o = ($urandom_range(0, 3) != 0);
                end
            end
            ar_ready_o = !rst && !rd_active && ($urandom_range(0, 3) != 0);
            aw_ready_o = !rst && !aw_got && ($urandom_range(0, 3) != 0);
            w_ready_o  = !rst && !w_got && ($urandom_range(0, 3) != 0);
            r_data_o   = mem.exists(rd_addr + {58'd0, rd_cnt, 3'b000}) ?
                         mem[rd_addr + {58'd0, rd_cnt, 3'b000}] : '0;
            r_last_o   = (rd_cnt == 3'd7);
            r_resp_o   = in_window(rd_addr) ? line_pkg::RESP_SLVERR : line_pkg::RESP_OKAY;
            b_resp_o   = in_window(wr_addr) ? line_pkg::RESP_SLVERR : line_pkg::RESP_OKAY;
        end
    end

endmodule

//--- verif/tb_line_mover.sv
`timescale 1ns/100ps

module tb_line_mover;

    localparam int unsigned     SEED      = 83393;
    localparam line_pkg::addr_t DATA_BASE = 64'h0000_1000;
    localparam line_pkg::addr_t ERR_BASE  = 64'h0004_0000;
    localparam line_pkg::addr_t ERR_SIZE  = 64'h80;    // two lines
    localparam int              NUM_RAND  = 48;
    localparam int              NUM_REQ   = NUM_RAND + 6;
    localparam int              TIMEOUT   = 200 * NUM_REQ;

    logic                  clock;
    logic                  reset;
    logic                  req_valid_i, req_ready_o, req_write_i, done_o;
    line_pkg::addr_t       req_addr_i, axi_ar_addr_o, axi_aw_addr_o;
    line_pkg::line_t       req_wdata_i, done_rdata_o;
    line_pkg::resp_t       done_resp_o, axi_r_resp_i, axi_b_resp_i;
    logic                  axi_ar_valid_o, axi_ar_ready_i, axi_r_valid_i, axi_r_ready_o;
    logic                  axi_aw_valid_o, axi_aw_ready_i, axi_w_valid_o, axi_w_ready_i;
    logic                  axi_r_last_i, axi_w_last_o, axi_b_valid_i, axi_b_ready_o;
    line_pkg::axi_id_t     axi_ar_id_o, axi_aw_id_o, axi_r_id_i, axi_b_id_i;
    logic [7:0]            axi_ar_len_o, axi_aw_len_o;
    logic [2:0]            axi_ar_size_o, axi_aw_size_o;
    logic [1:0]            axi_ar_burst_o, axi_aw_burst_o;
    line_pkg::beat_t       axi_r_data_i, axi_w_data_o;
    line_pkg::strb_t       axi_w_strb_o;

    line_pkg::line_t       ref_mem [line_pkg::addr_t];
    int                    check_errors = 0;
    int                    protocol_errors = 0;
    int                    accepts = 0;
    int                    dones = 0;
    int                    cycles = 0;
    int                    w_beats = 0;
    logic                  pending = 1'b0;
    logic                  ar_stall = 1'b0, aw_stall = 1'b0, w_stall = 1'b0;
    logic [80:0]           ar_now, aw_now, ar_prev, aw_prev;
    logic [72:0]           w_now, w_prev;

    assign axi_r_id_i = '0;
    assign axi_b_id_i = '0;
    assign ar_now = {axi_ar_addr_o, axi_ar_len_o, axi_ar_size_o, axi_ar_burst_o, axi_ar_id_o};
    assign aw_now = {axi_aw_addr_o, axi_aw_len_o, axi_aw_size_o, axi_aw_burst_o, axi_aw_id_o};
    assign w_now  = {axi_w_data_o, axi_w_strb_o, axi_w_last_o};

    line_mover_top line_mover_top_i (.*);

    axi_mem_model #(.ERR_BASE(ERR_BASE), .ERR_SIZE(ERR_SIZE)) u_mem (
        .clock (clock), .reset (reset),
        .ar_valid_i (axi_ar_valid_o), .ar_ready_o (axi_ar_ready_i), .ar_addr_i (axi_ar_addr_o),
        .r_valid_o (axi_r_valid_i), .r_ready_i (axi_r_ready_o), .r_data_o (axi_r_data_i),
        .r_resp_o (axi_r_resp_i), .r_last_o (axi_r_last_i),
        .aw_valid_i (axi_aw_valid_o), .aw_ready_o (axi_aw_ready_i), .aw_addr_i (axi_aw_addr_o),
        .w_valid_i (axi_w_valid_o), .w_ready_o (axi_w_ready_i), .w_data_i (axi_w_data_o),
        .w_last_i (axi_w_last_o),
        .b_valid_o (axi_b_valid_i), .b_ready_i (axi_b_ready_o), .b_resp_o (axi_b_resp_i)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic in_err_window(input line_pkg::addr_t a);
        return (a >= ERR_BASE) && (a < ERR_BASE + ERR_SIZE);
    endfunction

    function automatic line_pkg::line_t random_line();
        line_pkg::line_t l;
        int k;
        for (k = 0; k < 16; k++) begin
            l[k*32 +: 32] = $urandom;
        end
        return l;
    endfunction

    task automatic flag_failure(input string what);
        protocol_errors++;
        $display("time %0t: %s", $time, what);
    endtask

    task automatic report_problem(input string what);
        check_errors++;
        $display("time %0t: %s", $time, what);
    endtask

    task automatic check_value(input string name, input line_pkg::line_t got,
                               input line_pkg::line_t exp);
        assert (got === exp) else begin
            check_errors++;
            $display("error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic transfer_line(input logic wr, input line_pkg::addr_t addr,
                                 input line_pkg::line_t wdata);
        line_pkg::addr_t line_a;
        line_pkg::line_t exp_data;
        line_pkg::resp_t exp_resp;
        logic            hit;
        line_a   = addr & ~64'h3f;
        exp_resp = in_err_window(line_a) ? 2'b10 : 2'b00;    // slverr inside the window
        exp_data = ref_mem.exists(line_a) ? ref_mem[line_a] : '0;
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        do begin
            @(negedge clock);
            hit = req_ready_o;
            @(posedge clock);
            #1;
        end while (!hit);
        req_valid_i = 1'b0;
        do begin
            @(negedge clock);
            hit = done_o;
        end while (!hit);
        check_value("done_resp_o", line_pkg::line_t'(done_resp_o), line_pkg::line_t'(exp_resp));
        if (!wr) begin
            check_value("done_rdata_o", done_rdata_o, exp_data);
        end else if (exp_resp == 2'b00) begin
            ref_mem[line_a] = wdata;
        end
        @(posedge clock);
        #1;
    endtask

    // bus protocol and request handshake checks, mid-cycle
    always @(negedge clock) begin
        if (reset) begin
            {pending, ar_stall, aw_stall, w_stall} = '0;
            w_beats = 0;
        end else begin
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                assert (axi_ar_len_o == 8'd7 && axi_ar_size_o == 3'd3 && axi_ar_burst_o == 2'd1
                        && axi_ar_id_o == 4'd0 && axi_ar_addr_o[5:0] == 6'd0)
                    else flag_failure("AR handshake with wrong burst fields or unaligned address");
            end
            if (axi_aw_valid_o && axi_aw_ready_i) begin
                assert (axi_aw_len_o == 8'd7 && axi_aw_size_o == 3'd3 && axi_aw_burst_o == 2'd1
                        && axi_aw_id_o == 4'd0 && axi_aw_addr_o[5:0] == 6'd0)
                    else flag_failure("AW handshake with wrong burst fields or unaligned address");
            end
            if (axi_w_valid_o && axi_w_ready_i) begin
                assert (axi_w_strb_o == 8'hff) else flag_failure("W beat without full strobes");
                assert (axi_w_last_o == (w_beats == 7))
                    else flag_failure("wlast not on the eighth W beat of the burst");
                w_beats = axi_w_last_o ? 0 : w_beats + 1;
            end
            if (ar_stall) begin
                assert (axi_ar_valid_o && ar_now == ar_prev)
                    else flag_failure("AR dropped or changed while arready was low");
            end
            if (aw_stall) begin
                assert (axi_aw_valid_o && aw_now == aw_prev)
                    else flag_failure("AW dropped or changed while awready was low");
            end
            if (w_stall) begin
                assert (axi_w_valid_o && w_now == w_prev)
                    else flag_failure("W dropped or changed while wready was low");
            end
            ar_stall = axi_ar_valid_o && !axi_ar_ready_i;
            aw_stall = axi_aw_valid_o && !axi_aw_ready_i;
            w_stall  = axi_w_valid_o && !axi_w_ready_i;
            ar_prev  = ar_now;
            aw_prev  = aw_now;
            w_prev   = w_now;
            if (pending) begin
                assert (!req_ready_o) else flag_failure("req_ready_o high during a request");
            end
            if (done_o) begin
                assert (pending) else flag_failure("done_o pulse without an accepted request");
                pending = 1'b0;
                dones++;
            end
            if (req_valid_i && req_ready_o) begin
                pending = 1'b1;
                accepts++;
            end
        end
    end

    initial begin
        int unsigned     pick;
        line_pkg::addr_t line_a;
        void'($urandom(SEED));
        reset       = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        assert (!axi_ar_valid_o && !axi_aw_valid_o && !axi_w_valid_o && !axi_r_ready_o
                && !axi_b_ready_o && !done_o && req_ready_o)
            else report_problem("outputs not idle after reset");
        @(posedge clock);
        #1;

        transfer_line(1'b1, DATA_BASE + 64'h40, random_line());
        transfer_line(1'b0, DATA_BASE + 64'h5d, '0);           // unaligned read back
        transfer_line(1'b0, DATA_BASE + 64'h200, '0);          // never written
        transfer_line(1'b1, ERR_BASE + 64'h47, random_line());
        transfer_line(1'b0, ERR_BASE + 64'h40, '0);
        transfer_line(1'b1, DATA_BASE + 64'h7, random_line());

        // back to back mix over ten data lines and the error window
        repeat (NUM_RAND) begin
            pick   = $urandom_range(0, 11);
            line_a = (pick < 10) ? DATA_BASE + line_pkg::addr_t'(pick * 64)
                                 : ERR_BASE + line_pkg::addr_t'((pick - 10) * 64);
            transfer_line(1'($urandom_range(0, 1)),
                          line_a | line_pkg::addr_t'($urandom_range(0, 63)), random_line());
        end

        repeat (3) @(posedge clock);
        assert (accepts == NUM_REQ && dones == accepts)
            else report_problem("accepted requests and done_o pulses do not match");
        $display("errors: %0d check, %0d protocol; %0d requests, %0d done pulses",
                 check_errors, protocol_errors, accepts, dones);
        if (check_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
source/line_pkg.sv
source/line_req_if.sv
source/line_port.sv
source/axi_burst_master.sv
source/line_mover_top.sv
verif/axi_mem_model.sv
verif/tb_line_mover.sv

//--- run_sim.sh
#!/bin/sh
# build and run the line mover testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_line_mover \
    --Mdir obj_dir -o sim_line_mover > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/sim_line_mover > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
